//--- verilog/iot_pkg.sv
`default_nettype none

package iot_pkg;

	// ------------------------------------------------------------
	// data widths
	// ------------------------------------------------------------
	// one serial input byte
	typedef logic [7:0] byte_t;

	// full data word, byte 0 in bits 7:0
	typedef logic [127:0] word_t;

	// crc remainder
	typedef logic [2:0] crc_t;

	// byte step within a word
	typedef logic [3:0] step_t;

	// ------------------------------------------------------------
	// function select
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		FN_CRC      = 3'd3,
		FN_TOP2MAX  = 3'd4,
		FN_LAST2MIN = 3'd5
	} fn_t;

	// ------------------------------------------------------------
	// constants
	// ------------------------------------------------------------
	// bytes per word, also steps per word
	localparam int BYTES_PER_WORD = 16;

	// generator x^3+x^2+1 without its top term
	localparam crc_t CRC_POLY = 3'b101;

endpackage

`default_nettype wire

//--- verilog/step_if.sv
`timescale 1ns/100ps
`default_nettype none

// sequencer to engine bus, one byte step per cycle
interface step_if;
	import iot_pkg::*;

	// high while steps are being consumed
	logic active;
	// current step, 0 to 15
	step_t idx;
	// final step of the word
	logic last;
	// word under processing, held for all steps
	word_t word;

	// sequencer side drives everything
	modport seq (output active, output idx, output last, output word);

	// engines only listen
	modport eng (input active, input idx, input last, input word);

endinterface

`default_nettype wire

//--- verilog/byte_collector.sv
`timescale 1ns/100ps
`default_nettype none

module byte_collector (
	input  logic          clk,
	input  logic          rst,
	input  logic          in_en,
	input  iot_pkg::byte_t iot_in,
	output logic          word_done,
	output iot_pkg::word_t word
);
	import iot_pkg::*;

	// lane pointer for the next byte
	step_t cnt;
	// assembly register
	word_t asm_word;
	logic  last_byte;

	assign last_byte = in_en && (cnt == step_t'(BYTES_PER_WORD - 1));

	// ------------------------------------------------------------
	// byte counter and completion strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt       <= '0;
			word_done <= 1'b0;
		end else begin
			// wraps to lane 0 after the sixteenth byte
			if (in_en) begin
				cnt <= cnt + 1'b1;
			end
			word_done <= last_byte;
		end
	end

	// lane write
	always_ff @(posedge clk) begin
		if (in_en) begin
			asm_word[{cnt, 3'b000} +: 8] <= iot_in;
		end
	end

	// complete word is stable in the cycle of word_done
	assign word = asm_word;

endmodule

`default_nettype wire

//--- verilog/step_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module step_sequencer (
	input  logic           clk,
	input  logic           rst,
	input  logic           word_done,
	input  iot_pkg::word_t word,
	step_if.seq            st
);
	import iot_pkg::*;

	logic at_end;

	// last step of the current word
	assign at_end  = (st.idx == step_t'(BYTES_PER_WORD - 1));
	assign st.last = at_end;

	// ------------------------------------------------------------
	// step walk
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			st.active <= 1'b0;
			st.idx    <= '0;
		end else if (word_done) begin
			// fresh word, also a reload on step 15
			st.active <= 1'b1;
			st.idx    <= '0;
		end else if (st.active) begin
			if (at_end) begin
				st.active <= 1'b0;
			end
			// idx wraps back to 0 once the word is finished
			st.idx <= st.idx + 1'b1;
		end
	end

	// word latch
	// collector lane 0 may be overwritten on this same edge
	always_ff @(posedge clk) begin
		if (word_done) begin
			st.word <= word;
		end
	end

	// a new word only lands on an idle sequencer or on step 15
	property p_no_overrun;
		@(posedge clk) disable iff (rst)
			word_done |-> (!st.active || st.last);
	endproperty
	a_no_overrun: assert property (p_no_overrun)
		else $error("word arrived while sequencer busy");

endmodule

`default_nettype wire

//--- verilog/crc3_engine.sv
`timescale 1ns/100ps
`default_nettype none

module crc3_engine (
	input  logic          clk,
	input  logic          rst,
	input  iot_pkg::fn_t  fn_sel,
	step_if.eng           st,
	output logic          crc_done,
	output iot_pkg::crc_t crc
);
	import iot_pkg::*;

	// one long-division step, next dividend bit shifted in
	function automatic crc_t crc_bit(input crc_t r, input logic b);
		crc_t nr;
		nr = {r[1:0], b};
		if (r[2]) begin
			nr = nr ^ CRC_POLY;
		end
		return nr;
	endfunction

	// eight bits, msb first
	function automatic crc_t crc_fold(input crc_t r, input byte_t data);
		crc_t acc;
		acc = r;
		for (int i = 7; i >= 0; i--) begin
			acc = crc_bit(acc, data[i]);
		end
		return acc;
	endfunction

	logic  crc_en;
	byte_t cur_byte;
	crc_t  rem;
	crc_t  rem_next;

	assign crc_en = st.active && (fn_sel == FN_CRC);

	// msb byte first, so step idx takes byte 15-idx
	assign cur_byte = st.word[{~st.idx, 3'b000} +: 8];
	// step 0 restarts the division
	assign rem_next = crc_fold((st.idx == '0) ? crc_t'(0) : rem, cur_byte);

	// ------------------------------------------------------------
	// remainder and result
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (crc_en) begin
			rem <= rem_next;
			// append three zero bits on the final step
			if (st.last) begin
				crc <= crc_bit(crc_bit(crc_bit(rem_next, 1'b0), 1'b0), 1'b0);
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_done <= 1'b0;
		end else begin
			crc_done <= crc_en && st.last;
		end
	end

endmodule

`default_nettype wire

//--- verilog/extremum_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module extremum_tracker #(
	parameter int ROUND_WORDS = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  iot_pkg::fn_t   fn_sel,
	step_if.eng            st,
	output logic           pair_done,
	output iot_pkg::word_t best,
	output iot_pkg::word_t second
);
	import iot_pkg::*;

	localparam int CNT_W = $clog2(ROUND_WORDS);

	logic             track_en;
	logic             is_min;
	logic             clear;
	logic [CNT_W-1:0] round_cnt;
	logic             round_end;
	logic             first;
	word_t            worst;
	word_t            eff_best;
	word_t            eff_second;
	word_t            ins_best;
	word_t            ins_second;
	byte_t            cur_b;
	byte_t            best_b;
	byte_t            sec_b;
	logic             gt1, gt2, lt1, lt2;
	logic             gt1_n, gt2_n, lt1_n, lt2_n;
	logic             better1, better2;

	assign is_min   = (fn_sel == FN_LAST2MIN);
	assign track_en = (fn_sel == FN_TOP2MAX) || is_min;
	assign worst    = is_min ? '1 : '0;

	// a cleared round reads as the worst value
	assign eff_best   = clear ? worst : best;
	assign eff_second = clear ? worst : second;

	// ------------------------------------------------------------
	// byte-serial compare, lsb byte first
	// ------------------------------------------------------------
	assign first  = (st.idx == '0);
	assign cur_b  = st.word[{st.idx, 3'b000} +: 8];
	assign best_b = eff_best[{st.idx, 3'b000} +: 8];
	assign sec_b  = eff_second[{st.idx, 3'b000} +: 8];

	// equal bytes keep the lower-order verdict
	assign gt1_n = (cur_b == best_b) ? (!first && gt1) : (cur_b > best_b);
	assign lt1_n = (cur_b == best_b) ? (!first && lt1) : (cur_b < best_b);
	assign gt2_n = (cur_b == sec_b) ? (!first && gt2) : (cur_b > sec_b);
	assign lt2_n = (cur_b == sec_b) ? (!first && lt2) : (cur_b < sec_b);

	// strictly better than best, or else than second
	assign better1 = is_min ? lt1_n : gt1_n;
	assign better2 = is_min ? lt2_n : gt2_n;

	assign ins_best   = better1 ? st.word : eff_best;
	assign ins_second = better1 ? eff_best : (better2 ? st.word : eff_second);

	assign round_end = (round_cnt == CNT_W'(ROUND_WORDS - 1));

	// ------------------------------------------------------------
	// flags, round count, pair strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			{gt1, gt2, lt1, lt2} <= '0;
			clear     <= 1'b1;
			round_cnt <= '0;
			pair_done <= 1'b0;
		end else begin
			pair_done <= 1'b0;
			if (track_en && st.active) begin
				{gt1, gt2, lt1, lt2} <= {gt1_n, gt2_n, lt1_n, lt2_n};
				if (st.last) begin
					if (round_end) begin
						round_cnt <= '0;
						clear     <= 1'b1;
						pair_done <= 1'b1;
					end else begin
						round_cnt <= round_cnt + 1'b1;
						clear     <= 1'b0;
					end
				end
			end
		end
	end

	// trackers, they also present the pair until the next word ends
	always_ff @(posedge clk) begin
		if (track_en && st.active && st.last) begin
			best   <= ins_best;
			second <= ins_second;
		end
	end

	// best never falls behind second within a round
	property p_order;
		@(posedge clk) disable iff (rst)
			(track_en && !clear) |-> (is_min ? (best <= second) : (best >= second));
	endproperty
	a_order: assert property (p_order)
		else $error("best is worse than second");

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage (
	input  logic           clk,
	input  logic           rst,
	input  logic           crc_done,
	input  iot_pkg::crc_t  crc,
	input  logic           pair_done,
	input  iot_pkg::word_t best,
	input  iot_pkg::word_t second,
	output logic           valid,
	output iot_pkg::word_t iot_out
);
	import iot_pkg::*;

	// second word waits one cycle behind best
	word_t second_hold;
	logic  second_pend;

	// ------------------------------------------------------------
	// strobe control
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid       <= 1'b0;
			second_pend <= 1'b0;
		end else begin
			valid       <= crc_done || pair_done || second_pend;
			second_pend <= pair_done;
		end
	end

	// ------------------------------------------------------------
	// output data
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (crc_done) begin
			// remainder, zero extended
			iot_out <= word_t'(crc);
		end else if (pair_done) begin
			iot_out     <= best;
			second_hold <= second;
		end else if (second_pend) begin
			iot_out <= second_hold;
		end
		// otherwise hold the last shown value
	end

endmodule

`default_nettype wire

//--- verilog/iot_top.sv
`timescale 1ns/100ps
`default_nettype none

module iot_top #(
	parameter int ROUND_WORDS = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_en,
	input  iot_pkg::byte_t iot_in,
	input  iot_pkg::fn_t   fn_sel,
	output logic           valid,
	output iot_pkg::word_t iot_out
);
	import iot_pkg::*;

	// ------------------------------------------------------------
	// pipeline wires
	// ------------------------------------------------------------
	logic  word_done;
	word_t word;
	logic  crc_done;
	crc_t  crc;
	logic  pair_done;
	word_t best;
	word_t second;

	step_if st_bus ();

	// bytes in, word out
	byte_collector i_collector (
		.clk(clk), .rst(rst), .in_en(in_en), .iot_in(iot_in),
		.word_done(word_done), .word(word)
	);

	// latch and step through the word
	step_sequencer i_sequencer (
		.clk(clk), .rst(rst), .word_done(word_done), .word(word), .st(st_bus.seq)
	);

	crc3_engine i_crc (
		.clk(clk), .rst(rst), .fn_sel(fn_sel), .st(st_bus.eng),
		.crc_done(crc_done), .crc(crc)
	);

	extremum_tracker #(.ROUND_WORDS(ROUND_WORDS)) i_extremum (
		.clk(clk), .rst(rst), .fn_sel(fn_sel), .st(st_bus.eng),
		.pair_done(pair_done), .best(best), .second(second)
	);

	result_stage i_result (
		.clk(clk), .rst(rst), .crc_done(crc_done), .crc(crc),
		.pair_done(pair_done), .best(best), .second(second),
		.valid(valid), .iot_out(iot_out)
	);

endmodule

`default_nettype wire

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ------------------------------------------------------------
// scenario table
// ------------------------------------------------------------
localparam int DUP_NONE   = 0;
// copies of the previous word, two all-ones words in round 1
localparam int DUP_MAXREP = 1;
// round 0 is one word repeated, later rounds carry copies
localparam int DUP_EQUAL  = 2;

typedef struct packed {
	fn_t fn;
	int  words;
	bit  gaps;
	int  dup;
} row_t;

localparam int NUM_ROWS = 5;

// function, word count, idle gaps, duplicate mode
localparam row_t ROWS [NUM_ROWS] = '{
	'{FN_CRC,      12,              1'b0, DUP_NONE},
	'{FN_CRC,      10,              1'b1, DUP_NONE},
	'{FN_TOP2MAX,  3 * ROUND_WORDS, 1'b0, DUP_MAXREP},
	'{FN_LAST2MIN, 2 * ROUND_WORDS, 1'b1, DUP_EQUAL},
	'{FN_TOP2MAX,  ROUND_WORDS - 3, 1'b1, DUP_NONE}
};

// ------------------------------------------------------------
// reference models
// ------------------------------------------------------------
// long division of word followed by three zeros, generator 1101
function automatic crc_t crc_model(input word_t w);
	logic [130:0] div;
	div = {w, 3'b000};
	for (int i = 130; i >= 3; i--) begin
		if (div[i]) begin
			div[i -: 4] = div[i -: 4] ^ 4'b1101;
		end
	end
	return div[2:0];
endfunction

// strict unsigned order, direction by function
function automatic bit beats(input word_t a, input word_t b, input bit is_min);
	return is_min ? (a < b) : (a > b);
endfunction

// insertion into best and second
task automatic insert_word(input word_t w, input bit is_min,
	inout word_t top, inout word_t runner);
	if (beats(w, top, is_min)) begin
		runner = top;
		top    = w;
	end else if (beats(w, runner, is_min)) begin
		runner = w;
	end
endtask

`endif

//--- tests/tb_iot_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_iot_top;
	import iot_pkg::*;

	localparam int ROUND_WORDS     = 8;
	localparam int CLK_PERIOD      = 4;
	// one accepted byte plus at most three idle cycles
	localparam int MAX_BYTE_CYCLES = 4;
	// long enough for the second beat of a pair
	localparam int DRAIN_CYCLES    = 24;

	logic  clk;
	logic  rst;
	logic  in_en;
	byte_t iot_in;
	fn_t   fn_sel;
	logic  valid;
	word_t iot_out;

	`include "tb_vectors.svh"

	// rising edges seen so far
	int cyc = 0;
	int seed;
	// pending results, oldest first
	int    exp_cyc [$];
	bit    exp_is_crc [$];
	crc_t  exp_crc [$];
	word_t exp_word [$];

	iot_top #(.ROUND_WORDS(ROUND_WORDS)) i_dut (
		.clk(clk), .rst(rst), .in_en(in_en), .iot_in(iot_in),
		.fn_sel(fn_sel), .valid(valid), .iot_out(iot_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	// low three bits hold the remainder, rest zero
	task automatic compare_crc(input word_t got, input crc_t exp);
		if (got[2:0] !== exp || got[127:3] !== '0) begin
			stop_run($sformatf("Mismatch at %0t: crc expected %0h, got %0h",
				$time, exp, got));
		end
	endtask

	task automatic compare_word(input word_t got, input word_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Mismatch at %0t: word expected %h, got %h",
				$time, exp, got));
		end
	endtask

	task automatic check_result();
		int want_cyc;
		bit is_crc;
		if (exp_cyc.size() == 0) begin
			stop_run($sformatf("valid rose at %0t with no result pending", $time));
		end else begin
			want_cyc = exp_cyc.pop_front();
			is_crc   = exp_is_crc.pop_front();
			if (cyc != want_cyc) begin
				stop_run($sformatf("Mismatch at %0t: valid on edge %0d, expected edge %0d",
					$time, cyc, want_cyc));
			end else if (is_crc) begin
				compare_crc(iot_out, exp_crc.pop_front());
			end else begin
				compare_word(iot_out, exp_word.pop_front());
			end
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (!rst && valid) begin
			check_result();
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic apply_reset(input fn_t fn);
		rst    = 1'b1;
		in_en  = 1'b0;
		iot_in = '0;
		fn_sel = fn;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic random_word(output word_t w);
		for (int k = 0; k < 4; k++) begin
			w[k*32 +: 32] = $random(seed);
		end
	endtask

	task automatic pick_word(input row_t row, input int n, input word_t prev,
		input word_t fixed, output word_t w);
		random_word(w);
		if (row.dup == DUP_MAXREP) begin
			if (n == ROUND_WORDS + 3 || n == ROUND_WORDS + 6) begin
				w = '1;
			end else if (n % 4 == 1) begin
				w = prev;
			end
		end else if (row.dup == DUP_EQUAL) begin
			if (n < ROUND_WORDS) begin
				w = fixed;
			end else if (n % 4 == 1) begin
				w = prev;
			end
		end
	endtask

	// lowest byte first, last_cyc marks the final byte
	task automatic send_word(input word_t w, input bit gaps, output int last_cyc);
		int r;
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			if (gaps) begin
				r = $random(seed);
				repeat (r & 3) begin
					in_en = 1'b0;
					@(negedge clk);
				end
			end
			in_en    = 1'b1;
			iot_in   = w[b*8 +: 8];
			last_cyc = cyc;
			@(negedge clk);
		end
		in_en = 1'b0;
	endtask

	task automatic push_word(input word_t w, input int at_cyc);
		exp_cyc.push_back(at_cyc);
		exp_is_crc.push_back(1'b0);
		exp_word.push_back(w);
	endtask

	task automatic run_row(input row_t row);
		word_t w;
		word_t prev;
		word_t fixed;
		word_t top;
		word_t runner;
		int    last_cyc;
		bit    is_min;
		is_min = (row.fn == FN_LAST2MIN);
		apply_reset(row.fn);
		random_word(fixed);
		prev = '0;
		top  = '0;
		if (is_min) begin
			top = '1;
		end
		runner = top;
		for (int n = 0; n < row.words; n++) begin
			pick_word(row, n, prev, fixed, w);
			send_word(w, row.gaps, last_cyc);
			prev = w;
			// accept edge is one past last_cyc, valid 18 edges later
			if (row.fn == FN_CRC) begin
				exp_cyc.push_back(last_cyc + 19);
				exp_is_crc.push_back(1'b1);
				exp_crc.push_back(crc_model(w));
			end else begin
				insert_word(w, is_min, top, runner);
				if (n % ROUND_WORDS == ROUND_WORDS - 1) begin
					push_word(top, last_cyc + 19);
					push_word(runner, last_cyc + 20);
					// next round starts from the worst value
					top = is_min ? {128{1'b1}} : '0;
					runner = top;
				end
			end
		end
		repeat (DRAIN_CYCLES) @(negedge clk);
		if (exp_cyc.size() != 0) begin
			stop_run($sformatf("%0d expected results never showed a valid", exp_cyc.size()));
		end
	endtask

	function automatic int total_bytes();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			sum += ROWS[i].words * BYTES_PER_WORD;
		end
		return sum;
	endfunction

	initial begin
		clk    = 1'b0;
		rst    = 1'b1;
		in_en  = 1'b0;
		iot_in = '0;
		fn_sel = FN_CRC;
		seed   = 32'hfd78;
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(ROWS[i]);
		end
		$display("Done: no errors");
		$finish;
	end

	// watchdog, bytes at the slowest rate plus reset and drain per row
	initial begin
		int limit;
		limit = (total_bytes() * MAX_BYTE_CYCLES + NUM_ROWS * (DRAIN_CYCLES + 40)) * CLK_PERIOD;
		#(limit);
		$display("timeout: the run did not finish within %0d ns", limit);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
verilog/iot_pkg.sv
verilog/step_if.sv
verilog/byte_collector.sv
verilog/step_sequencer.sv
verilog/crc3_engine.sv
verilog/extremum_tracker.sv
verilog/result_stage.sv
verilog/iot_top.sv
tests/tb_iot_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_iot_top \
	-f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_iot_top
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
